//--- build.f
verilog/cpuPkg.sv
verilog/mdDecode.sv
verilog/mdMultiplier.sv
verilog/mdDivider.sv
verilog/hiLoUnit.sv
verilog/exMultDiv.sv
test/clockGen.sv
test/tbExMultDiv.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --timescale 1ns/100ps \
        --top-module tbExMultDiv -f build.f -o simv \
    && ./obj_dir/simv \
    || exit 1

//--- test/clockGen.sv
module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD = 8;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk); // released on a falling edge
        reset = 1'b0;
    end

endmodule

//--- test/tbExMultDiv.sv
module tbExMultDiv;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MUL_BUSY = 3;
    localparam int DIV_BUSY = 34;
    localparam int ACC_SET = 0;
    localparam int ACC_ADD = 1;
    localparam int ACC_SUB = 2;
    localparam int CYCLE_LIMIT = 16 + 60 * 40; // reset plus 60 ops of 40 cycles

    logic clk, reset;
    cpuPkg::instrWord_t instr;
    logic instrValid;
    logic [31:0] dataRs, dataRt;
    logic busy;
    logic [31:0] out;

    logic [63:0] model;     // {HI, LO} as the testbench expects it
    logic [31:0] rngState;
    int opLen;              // busy length of the op being driven
    int lastLen;
    int busyLen;
    int cycles = 0;

    logic [31:0] edgeA [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    logic [31:0] edgeB [5] = '{32'h0, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
    logic [31:0] divA [10] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'h8000_0000,
                               32'd12345, 32'hffff_cfc7, 32'hdead_beef, 32'h8000_0000,
                               32'hffff_ffff};
    logic [31:0] divB [10] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_ffff,
                               32'd0, 32'd0, 32'd0, 32'hffff_ffff, 32'd16};
    logic        divU [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    clockGen uClock (.clk(clk), .reset(reset));

    exMultDiv UUT (
        .clk(clk), .reset(reset), .instr(instr), .instrValid(instrValid),
        .dataRs(dataRs), .dataRt(dataRt), .busy(busy), .out(out)
    );

    task automatic stopFailed();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
        stopFailed();
    endtask

    task automatic reportProblem(input string what);
        $display("ERROR: %s", what);
        stopFailed();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: no finish after %0d cycles", cycles);
            stopFailed();
        end
    end

    // length of each busy run and the op that started it
    always @(posedge clk) begin
        if (reset) begin
            busyLen <= 0;
            lastLen <= 0;
        end
        else begin
            busyLen <= busy ? busyLen + 1 : 0;
            if (instrValid && !busy) lastLen <= opLen;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (instrValid && !busy && opLen != 0) |=> busy)
        else reportProblem("busy did not rise after a long op was issued");

    assert property (@(posedge clk) disable iff (reset)
        (instrValid && !busy && opLen == 0) |=> !busy)
        else reportProblem("busy rose after a move or an unrelated op");

    assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> busyLen == lastLen)
        else reportMismatch("busy length", $sampled(lastLen), $sampled(busyLen));

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic cpuPkg::instrWord_t makeWord(input logic [5:0] opc, input logic [5:0] fn);
        cpuPkg::instrWord_t w;
        w.r.opcode = opc;
        w.r.rs = 5'd8;
        w.r.rt = 5'd9;
        w.r.rd = 5'd0;
        w.r.shamt = 5'd0;
        w.r.funct = fn;
        return w;
    endfunction

    function automatic logic [63:0] mulRef(input logic [31:0] a, input logic [31:0] b,
                                           input logic isUnsigned);
        logic [63:0] wa, wb;
        wa = isUnsigned ? {32'd0, a} : {{32{a[31]}}, a};
        wb = isUnsigned ? {32'd0, b} : {{32{b[31]}}, b};
        return wa * wb; // low 64 bits agree for both signs
    endfunction

    // {remainder, quotient}
    function automatic logic [63:0] divRef(input logic [31:0] a, input logic [31:0] b,
                                           input logic isUnsigned);
        logic signed [63:0] sa, sb, sq, sr;
        logic [31:0] q, r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        if (b == 32'd0) begin
            q = '1;
            r = a;
        end
        else if (isUnsigned) begin
            q = a / b;
            r = a % b;
        end
        else begin
            sq = sa / sb; // truncates toward zero
            sr = sa % sb;
            q = sq[31:0];
            r = sr[31:0];
        end
        return {r, q};
    endfunction

    task automatic startOp(input cpuPkg::instrWord_t w, input logic [31:0] rs,
                           input logic [31:0] rt, input int len);
        @(negedge clk);
        instr = w;
        instrValid = 1'b1;
        dataRs = rs;
        dataRt = rt;
        opLen = len;
        while (busy) @(negedge clk); // held until accepted
        @(negedge clk);
        instrValid = 1'b0;
    endtask

    task automatic runOp(input cpuPkg::instrWord_t w, input logic [31:0] rs,
                         input logic [31:0] rt, input int len);
        startOp(w, rs, rt, len);
        while (busy) @(negedge clk);
    endtask

    task automatic readReg(input logic selHi, input logic [31:0] expected, input string name);
        @(negedge clk);
        instr = makeWord(cpuPkg::OPC_SPECIAL, selHi ? cpuPkg::FN_MFHI : cpuPkg::FN_MFLO);
        instrValid = 1'b1;
        opLen = 0;
        while (busy) begin
            #2;
            assert (out == 32'd0) else reportMismatch({name, " while busy"}, 32'd0, out);
            @(negedge clk);
        end
        #2;
        assert (out == expected) else reportMismatch(name, expected, out);
    endtask

    task automatic checkHiLo(input string name);
        readReg(1'b1, model[63:32], {name, " HI"});
        readReg(1'b0, model[31:0], {name, " LO"});
    endtask

    task automatic loadHiLo(input logic [31:0] hi, input logic [31:0] lo);
        runOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MTHI), hi, 32'd0, 0);
        runOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MTLO), lo, 32'd0, 0);
        model = {hi, lo};
    endtask

    task automatic checkUnrelated();
        @(negedge clk);
        instr = makeWord(cpuPkg::OPC_SPECIAL, 6'h20); // ADD
        instrValid = 1'b1;
        opLen = 0;
        #2;
        assert (out == 32'd0) else reportMismatch("unrelated op", 32'd0, out);
        @(negedge clk);
        instr = makeWord(cpuPkg::OPC_SPECIAL2, cpuPkg::FN_MFHI);
        #2;
        assert (out == 32'd0) else reportMismatch("SPECIAL2 with MFHI funct", 32'd0, out);
        @(negedge clk);
        instr = makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MFHI);
        instrValid = 1'b0;
        #2;
        assert (out == 32'd0) else reportMismatch("MFHI without valid", 32'd0, out);
    endtask

    task automatic doMul(input logic [5:0] opc, input logic [5:0] fn, input logic isUnsigned,
                         input int acc, input logic [31:0] a, input logic [31:0] b,
                         input string name);
        logic [63:0] p;
        p = mulRef(a, b, isUnsigned);
        if (acc == ACC_ADD) model = model + p;
        else if (acc == ACC_SUB) model = model - p; // wraps mod 2^64
        else model = p;
        runOp(makeWord(opc, fn), a, b, MUL_BUSY);
        checkHiLo(name);
    endtask

    task automatic doDiv(input logic [31:0] a, input logic [31:0] b, input logic isUnsigned,
                         input string name);
        model = divRef(a, b, isUnsigned);
        runOp(makeWord(cpuPkg::OPC_SPECIAL, isUnsigned ? cpuPkg::FN_DIVU : cpuPkg::FN_DIV),
              a, b, DIV_BUSY);
        checkHiLo(name);
    endtask

    initial begin
        logic [31:0] a, b, c;
        logic [5:0] fn;
        logic [63:0] p;
        instr = '0;
        instrValid = 1'b0;
        dataRs = '0;
        dataRt = '0;
        opLen = 0;
        model = '0;
        rngState = 32'd41;
        @(negedge reset);

        assert (busy == 1'b0) else reportProblem("busy is high after reset");
        readReg(1'b1, 32'd0, "reset HI");
        readReg(1'b0, 32'd0, "reset LO");

        loadHiLo(32'h1234_5678, 32'h9abc_def0);
        checkHiLo("move");
        checkUnrelated();

        for (int i = 0; i < 5; i++) begin
            doMul(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MULT, 1'b0, ACC_SET, edgeA[i], edgeB[i],
                  $sformatf("MULT edge %0d", i));
            doMul(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MULTU, 1'b1, ACC_SET, edgeA[i], edgeB[i],
                  $sformatf("MULTU edge %0d", i));
        end
        for (int i = 0; i < 12; i++) begin
            a = randWord();
            b = randWord();
            fn = i[0] ? cpuPkg::FN_MULTU : cpuPkg::FN_MULT;
            doMul(cpuPkg::OPC_SPECIAL, fn, i[0], ACC_SET, a, b, $sformatf("MULT rand %0d", i));
        end

        // accumulate chains reloaded every third op
        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 0) loadHiLo(randWord(), randWord());
            a = randWord();
            b = randWord();
            case (i % 4)
                0: fn = cpuPkg::FN_MADD;
                1: fn = cpuPkg::FN_MADDU;
                2: fn = cpuPkg::FN_MSUB;
                default: fn = cpuPkg::FN_MSUBU;
            endcase
            doMul(cpuPkg::OPC_SPECIAL2, fn, i[0], (i % 4 < 2) ? ACC_ADD : ACC_SUB, a, b,
                  $sformatf("accumulate %0d", i));
        end
        loadHiLo(32'hffff_ffff, 32'hffff_ffff);
        doMul(cpuPkg::OPC_SPECIAL2, cpuPkg::FN_MADDU, 1'b1, ACC_ADD, 32'd2, 32'd3, "MADDU wrap");
        loadHiLo(32'd0, 32'd0);
        doMul(cpuPkg::OPC_SPECIAL2, cpuPkg::FN_MSUBU, 1'b1, ACC_SUB, 32'd1, 32'd1, "MSUBU wrap");
        loadHiLo(32'd0, 32'd5);
        doMul(cpuPkg::OPC_SPECIAL2, cpuPkg::FN_MSUB, 1'b0, ACC_SUB, 32'hffff_ffff, 32'd3,
              "MSUB negative");

        for (int i = 0; i < 10; i++) begin
            doDiv(divA[i], divB[i], divU[i], $sformatf("DIV edge %0d", i));
        end
        for (int i = 0; i < 8; i++) begin
            a = randWord();
            b = randWord();
            if (i[1]) b = b >> 20; // small divisors for larger quotients
            doDiv(a, b, i[0], $sformatf("DIV rand %0d", i));
        end

        // MFLO held during a divide
        a = randWord();
        b = (randWord() >> 16) | 32'd1;
        model = divRef(a, b, 1'b0);
        startOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_DIV), a, b, DIV_BUSY);
        readReg(1'b0, model[31:0], "stall MFLO");
        readReg(1'b1, model[63:32], "stall MFHI");

        // MFHI held during a multiply
        a = randWord();
        b = randWord();
        model = mulRef(a, b, 1'b0);
        startOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MULT), a, b, MUL_BUSY);
        readReg(1'b1, model[63:32], "stall MFHI after MULT");
        readReg(1'b0, model[31:0], "stall MFLO after MULT");

        // MTHI held during a multiply
        a = randWord();
        b = randWord();
        c = randWord();
        p = mulRef(a, b, 1'b1);
        startOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MULTU), a, b, MUL_BUSY);
        runOp(makeWord(cpuPkg::OPC_SPECIAL, cpuPkg::FN_MTHI), c, 32'd0, 0);
        model = {c, p[31:0]};
        checkHiLo("stall MTHI");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

    // one instruction word, two field layouts
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
    } instrWord_t;

    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;

    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_MADD  = 6'h00; // SPECIAL2 group
    localparam logic [5:0] FN_MADDU = 6'h01;
    localparam logic [5:0] FN_MSUB  = 6'h04;
    localparam logic [5:0] FN_MSUBU = 6'h05;

    localparam int MUL_STAGES = 3;
    localparam int DIV_CYCLES = 34; // load + 32 steps + fix-up

    // nine ops, so four bits
    typedef enum logic [3:0] {
        mdNop, mdMult, mdMadd, mdMsub, mdDiv, mdMthi, mdMtlo, mdMfhi, mdMflo
    } mdOp_t;

    typedef struct packed {
        mdOp_t op;
        logic  isUnsigned;
    } mdCtrl_t;

    typedef enum logic [1:0] {accSet, accAdd, accSub} accMode_t;

    typedef struct packed {
        logic [32:0] a; // already extended
        logic [32:0] b;
        accMode_t    mode;
    } mulReq_t;

    typedef struct packed {
        logic [31:0] dividend;
        logic [31:0] divisor;
        logic        isUnsigned;
    } divReq_t;

    typedef struct packed {
        logic [31:0] quotient;
        logic [31:0] remainder;
    } divRes_t;

endpackage

//--- verilog/exMultDiv.sv
module exMultDiv (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::instrWord_t instr,
    input  logic               instrValid,
    input  logic [31:0]        dataRs,
    input  logic [31:0]        dataRt,
    output logic               busy,
    output logic [31:0]        out
);

    cpuPkg::mdCtrl_t  ctrl;
    logic             mulStart, mulDone;
    cpuPkg::mulReq_t  mulReq;
    logic [63:0]      mulProduct;
    cpuPkg::accMode_t mulMode;
    logic             divStart, divDone;
    cpuPkg::divReq_t  divReq;
    cpuPkg::divRes_t  divRes;

    mdDecode uDecode (
        .instr(instr), .instrValid(instrValid), .ctrl(ctrl)
    );

    hiLoUnit uHiLo (
        .clk(clk), .reset(reset), .ctrl(ctrl),
        .dataRs(dataRs), .dataRt(dataRt), .busy(busy), .out(out),
        .mulStart(mulStart), .mulReq(mulReq),
        .mulDone(mulDone), .mulProduct(mulProduct), .mulMode(mulMode),
        .divStart(divStart), .divReq(divReq),
        .divDone(divDone), .divRes(divRes)
    );

    mdMultiplier uMul (
        .clk(clk), .reset(reset), .start(mulStart), .req(mulReq),
        .done(mulDone), .product(mulProduct), .mode(mulMode)
    );

    mdDivider uDiv (
        .clk(clk), .reset(reset), .start(divStart), .req(divReq),
        .done(divDone), .res(divRes)
    );

endmodule

//--- verilog/hiLoUnit.sv
module hiLoUnit (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::mdCtrl_t  ctrl,
    input  logic [31:0]      dataRs,
    input  logic [31:0]      dataRt,
    output logic             busy,
    output logic [31:0]      out,
    output logic             mulStart,
    output cpuPkg::mulReq_t  mulReq,
    input  logic             mulDone,
    input  logic [63:0]      mulProduct,
    input  cpuPkg::accMode_t mulMode,
    output logic             divStart,
    output cpuPkg::divReq_t  divReq,
    input  logic             divDone,
    input  cpuPkg::divRes_t  divRes
);

    logic [31:0] hi, lo;
    logic        issue;
    logic        isMul;
    logic        extRs, extRt;
    logic [63:0] accNext;

    assign issue = !busy; // ops are held by the issuer while busy
    assign isMul = (ctrl.op == cpuPkg::mdMult) || (ctrl.op == cpuPkg::mdMadd) ||
                   (ctrl.op == cpuPkg::mdMsub);

    assign mulStart = issue && isMul;
    assign divStart = issue && (ctrl.op == cpuPkg::mdDiv);

    // sign bit to the 33rd position for the signed forms
    assign extRs = !ctrl.isUnsigned && dataRs[31];
    assign extRt = !ctrl.isUnsigned && dataRt[31];

    always_comb begin
        mulReq.a = {extRs, dataRs};
        mulReq.b = {extRt, dataRt};
        case (ctrl.op)
            cpuPkg::mdMadd: mulReq.mode = cpuPkg::accAdd;
            cpuPkg::mdMsub: mulReq.mode = cpuPkg::accSub;
            default: mulReq.mode = cpuPkg::accSet;
        endcase
    end

    always_comb begin
        divReq.dividend = dataRs;
        divReq.divisor = dataRt;
        divReq.isUnsigned = ctrl.isUnsigned;
    end

    always_comb begin
        case (mulMode)
            cpuPkg::accAdd: accNext = {hi, lo} + mulProduct;
            cpuPkg::accSub: accNext = {hi, lo} - mulProduct;
            default: accNext = mulProduct;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            hi <= '0;
            lo <= '0;
        end
        else begin
            if (mulStart || divStart) begin
                busy <= 1'b1;
            end
            else if (mulDone || divDone) begin
                busy <= 1'b0;
            end

            if (mulDone) begin
                {hi, lo} <= accNext;
            end
            else if (divDone) begin
                hi <= divRes.remainder;
                lo <= divRes.quotient;
            end
            else if (issue && ctrl.op == cpuPkg::mdMthi) begin
                hi <= dataRs;
            end
            else if (issue && ctrl.op == cpuPkg::mdMtlo) begin
                lo <= dataRs;
            end
        end
    end

    // move-from answers in the same cycle
    always_comb begin
        out = '0;
        if (issue && ctrl.op == cpuPkg::mdMfhi) begin
            out = hi;
        end
        else if (issue && ctrl.op == cpuPkg::mdMflo) begin
            out = lo;
        end
    end

endmodule

//--- verilog/mdDecode.sv
module mdDecode (
    input  cpuPkg::instrWord_t instr,
    input  logic               instrValid,
    output cpuPkg::mdCtrl_t    ctrl
);

    always_comb begin
        ctrl.op = cpuPkg::mdNop;
        ctrl.isUnsigned = 1'b0;
        if (instrValid) begin
            if (instr.i.opcode == cpuPkg::OPC_SPECIAL) begin
                case (instr.r.funct)
                    cpuPkg::FN_MULT: ctrl.op = cpuPkg::mdMult;
                    cpuPkg::FN_MULTU: begin
                        ctrl.op = cpuPkg::mdMult;
                        ctrl.isUnsigned = 1'b1;
                    end
                    cpuPkg::FN_DIV: ctrl.op = cpuPkg::mdDiv;
                    cpuPkg::FN_DIVU: begin
                        ctrl.op = cpuPkg::mdDiv;
                        ctrl.isUnsigned = 1'b1;
                    end
                    cpuPkg::FN_MTHI: ctrl.op = cpuPkg::mdMthi;
                    cpuPkg::FN_MTLO: ctrl.op = cpuPkg::mdMtlo;
                    cpuPkg::FN_MFHI: ctrl.op = cpuPkg::mdMfhi;
                    cpuPkg::FN_MFLO: ctrl.op = cpuPkg::mdMflo;
                    default: ; // not ours
                endcase
            end
            else if (instr.i.opcode == cpuPkg::OPC_SPECIAL2) begin
                // accumulate forms
                case (instr.r.funct)
                    cpuPkg::FN_MADD: ctrl.op = cpuPkg::mdMadd;
                    cpuPkg::FN_MADDU: begin
                        ctrl.op = cpuPkg::mdMadd;
                        ctrl.isUnsigned = 1'b1;
                    end
                    cpuPkg::FN_MSUB: ctrl.op = cpuPkg::mdMsub;
                    cpuPkg::FN_MSUBU: begin
                        ctrl.op = cpuPkg::mdMsub;
                        ctrl.isUnsigned = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/mdDivider.sv
module mdDivider (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  cpuPkg::divReq_t req,
    output logic            done,
    output cpuPkg::divRes_t res
);

    logic        active;
    logic [5:0]  count;   // steps left
    logic [31:0] quo;     // dividend shifts out, quotient shifts in
    logic [31:0] rem;
    logic [31:0] divisor;
    logic        negQuot, negRem;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic        load;

    function automatic logic [31:0] magnitude(input logic [31:0] v, input logic isSigned);
        return (isSigned && v[31]) ? -v : v;
    endfunction

    assign load = start && !active;
    assign shifted = {rem, quo[31]};
    assign diff = {1'b0, shifted} - {2'b0, divisor}; // bit 33 set means no fit

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end
        else begin
            done <= 1'b0;
            if (load) begin
                active <= 1'b1;
                count <= 6'(cpuPkg::DIV_CYCLES - 2);
            end
            else if (active) begin
                if (count != 0) begin
                    count <= count - 6'd1;
                end
                else begin
                    active <= 1'b0; // fix-up cycle
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo <= magnitude(req.dividend, !req.isUnsigned);
            divisor <= magnitude(req.divisor, !req.isUnsigned);
            rem <= '0;
            // zero divisor keeps all-ones quotient unsigned
            negQuot <= !req.isUnsigned && (req.dividend[31] ^ req.divisor[31])
                       && (req.divisor != '0);
            negRem <= !req.isUnsigned && req.dividend[31];
        end
        else if (active && count != 0) begin
            if (!diff[33]) begin
                rem <= diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end
            else begin
                rem <= shifted[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
        else if (active) begin
            res.quotient <= negQuot ? -quo : quo;
            res.remainder <= negRem ? -rem : rem; // sign follows dividend
        end
    end

endmodule

//--- verilog/mdMultiplier.sv
module mdMultiplier (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpuPkg::mulReq_t   req,
    output logic              done,
    output logic [63:0]       product,
    output cpuPkg::accMode_t  mode
);

    logic [cpuPkg::MUL_STAGES-1:0] validPipe;
    cpuPkg::accMode_t modePipe [cpuPkg::MUL_STAGES];

    logic signed [15:0] aHi, bHi; // a = aHi * 2^17 + aLo
    logic [16:0] aLo, bLo;
    logic signed [31:0] pHH;
    logic signed [33:0] pHL, pLH;
    logic [33:0] pLL;
    logic signed [63:0] sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
        end
        else begin
            validPipe <= {validPipe[cpuPkg::MUL_STAGES-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        modePipe[0] <= req.mode;
        for (int s = 1; s < cpuPkg::MUL_STAGES; s++) begin
            modePipe[s] <= modePipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        aHi <= req.a[32:17];
        aLo <= req.a[16:0];
        bHi <= req.b[32:17];
        bLo <= req.b[16:0];
        pHH <= aHi * bHi;
        pHL <= aHi * $signed({1'b0, bLo});
        pLH <= $signed({1'b0, aLo}) * bHi;
        pLL <= aLo * bLo;
        product <= sum;
    end

    // low part is unsigned, zero-pad before adding
    assign sum = (pHH <<< 34) + (pHL <<< 17) + (pLH <<< 17) + $signed({30'b0, pLL});

    assign done = validPipe[cpuPkg::MUL_STAGES-1];
    assign mode = modePipe[cpuPkg::MUL_STAGES-1];

endmodule
